//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module FetchStageTb \
    -f verilog.f -o simFetchStage

simOutput=$(./obj_dir/simFetchStage) || true
echo "$simOutput"

if echo "$simOutput" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

//--- source/FetchControl.sv
`timescale 1ns/1ns

module FetchControl (
    input  logic        clk,
    input  logic        rstN,
    input  logic        cfgWe,          // Register write strobe
    input  logic [1:0]  cfgAddr,
    input  logic [31:0] cfgWdata,
    output logic [31:0] cfgRdata,       // Combinational readback
    input  logic        idValid,        // From IF/ID
    input  logic        stall,
    output logic        run,
    output logic        restart,        // One cycle pulse
    output logic [31:0] bootPc
);

    import fetchPkg::*;

    logic        ctrlWrite;
    logic        bootWrite;
    logic [31:0] deliveredCount;        // Instructions accepted by decode

    assign ctrlWrite = cfgWe && (cfgAddr == CFG_CTRL);
    assign bootWrite = cfgWe && (cfgAddr == CFG_BOOT);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            run            <= 1'b0;
            restart        <= 1'b0;
            bootPc         <= '0;
            deliveredCount <= '0;
        end else begin
            restart <= ctrlWrite && cfgWdata[1];    // Self clearing
            if (ctrlWrite) begin
                run <= cfgWdata[0];
            end
            if (bootWrite) begin
                bootPc <= cfgWdata;
            end
            // A word counts once decode takes it
            if (idValid && !stall) begin
                deliveredCount <= deliveredCount + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfgAddr)
            CFG_CTRL:  cfgRdata = {30'd0, restart, run};
            CFG_BOOT:  cfgRdata = bootPc;
            CFG_COUNT: cfgRdata = deliveredCount;
            default:   cfgRdata = '0;                   // Unmapped
        endcase
    end

endmodule

//--- source/FetchDecodeReg.sv
`timescale 1ns/1ns

module FetchDecodeReg (
    input  logic               clk,
    input  logic               rstN,
    input  logic               run,
    input  logic               restart,
    input  logic               stall,
    input  logic               redirectValid,
    input  fetchPkg::instrWord fetchInstr,
    input  logic [31:0]        pcPlus4,
    output fetchPkg::instrWord idInstr,
    output logic [31:0]        idPcPlus4,      // Link value for jal
    output logic               idValid
);

    import fetchPkg::*;

    instrWord captureInstr;

    assign captureInstr = fetchInstr;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            idValid <= 1'b0;
        end else if (restart || redirectValid) begin
            idValid <= 1'b0;                        // Bubble, old path dropped
        end else if (stall) begin
            idValid <= idValid;                     // Decode not ready
        end else begin
            idValid <= run;                         // Nothing fetched when idle
        end
    end

    // Payload follows the fetch whenever decode moves
    always_ff @(posedge clk) begin
        if (!stall) begin
            idInstr   <= captureInstr;
            idPcPlus4 <= pcPlus4;
        end
    end

endmodule

//--- source/FetchStage.sv
`timescale 1ns/1ns

module FetchStage #(
    parameter int MEM_WORDS = 512
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         progWe,         // Program load port
    input  logic [$clog2(MEM_WORDS)-1:0] progAddr,
    input  logic [31:0]                  progData,
    input  logic                         cfgWe,          // Control register port
    input  logic [1:0]                   cfgAddr,
    input  logic [31:0]                  cfgWdata,
    output logic [31:0]                  cfgRdata,
    input  logic                         stall,
    input  logic                         redirectValid,
    input  logic [31:0]                  redirectPc,
    output fetchPkg::instrWord           idInstr,        // To decode
    output logic [31:0]                  idPcPlus4,
    output logic                         idValid
);

    import fetchPkg::*;

    logic        run;
    logic        restart;
    logic [31:0] bootPc;
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    instrWord    fetchInstr;        // Memory output, seen by PC and IF/ID

    InstructionMemory #(
        .MEM_WORDS(MEM_WORDS)
    ) imem (
        .clk       (clk),
        .progWe    (progWe),
        .progAddr  (progAddr),
        .progData  (progData),
        .pc        (pc),
        .fetchInstr(fetchInstr)
    );

    FetchControl ctrl (
        .clk     (clk),
        .rstN    (rstN),
        .cfgWe   (cfgWe),
        .cfgAddr (cfgAddr),
        .cfgWdata(cfgWdata),
        .cfgRdata(cfgRdata),
        .idValid (idValid),
        .stall   (stall),
        .run     (run),
        .restart (restart),
        .bootPc  (bootPc)
    );

    ProgramCounter pcUnit (
        .clk          (clk),
        .rstN         (rstN),
        .run          (run),
        .restart      (restart),
        .bootPc       (bootPc),
        .stall        (stall),
        .redirectValid(redirectValid),
        .redirectPc   (redirectPc),
        .fetchInstr   (fetchInstr),
        .pc           (pc),
        .pcPlus4      (pcPlus4)
    );

    FetchDecodeReg ifId (
        .clk          (clk),
        .rstN         (rstN),
        .run          (run),
        .restart      (restart),
        .stall        (stall),
        .redirectValid(redirectValid),
        .fetchInstr   (fetchInstr),
        .pcPlus4      (pcPlus4),
        .idInstr      (idInstr),
        .idPcPlus4    (idPcPlus4),
        .idValid      (idValid)
    );

endmodule

//--- source/InstructionMemory.sv
`timescale 1ns/1ns

module InstructionMemory #(
    parameter int MEM_WORDS = 512                       // Power of two
) (
    input  logic                         clk,
    input  logic                         progWe,        // Program write strobe
    input  logic [$clog2(MEM_WORDS)-1:0] progAddr,      // Word index
    input  logic [31:0]                  progData,
    input  logic [31:0]                  pc,            // Byte address
    output logic [31:0]                  fetchInstr
);

    localparam int ADDR_BITS = $clog2(MEM_WORDS);

    logic [31:0]          memory [0:MEM_WORDS-1];      // Word storage
    logic [ADDR_BITS-1:0] readIndex;

    // Program load port, lands at the edge
    always_ff @(posedge clk) begin
        if (progWe) begin
            memory[progAddr] <= progData;
        end
    end

    // Byte offset bits dropped, upper bits wrap
    assign readIndex = pc[ADDR_BITS+1:2];

    assign fetchInstr = memory[readIndex];              // Zero cycle read

endmodule

//--- source/ProgramCounter.sv
`timescale 1ns/1ns

module ProgramCounter (
    input  logic              clk,
    input  logic              rstN,
    input  logic              run,
    input  logic              restart,          // Load boot address
    input  logic [31:0]       bootPc,
    input  logic              stall,            // Hold request from decode
    input  logic              redirectValid,    // Branch or jr from later stage
    input  logic [31:0]       redirectPc,
    input  fetchPkg::instrWord fetchInstr,      // Word at current PC
    output logic [31:0]       pc,
    output logic [31:0]       pcPlus4
);

    import fetchPkg::*;

    logic        isJump;
    logic [31:0] jumpTarget;

    assign pcPlus4 = pc + 32'd4;

    // j and jal resolved here so no bubble follows them
    assign isJump = (fetchInstr.jType.opcode == OP_J)
                 || (fetchInstr.jType.opcode == OP_JAL);

    // Region of PC+4, then word target, then byte offset
    assign jumpTarget = {pcPlus4[31:28], fetchInstr.jType.target, 2'b00};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (restart) begin
            pc <= bootPc;
        end else if (redirectValid) begin
            pc <= redirectPc;                   // Wins over stall
        end else if (stall || !run) begin
            pc <= pc;
        end else if (isJump) begin
            pc <= jumpTarget;
        end else begin
            pc <= pcPlus4;                      // Sequential
        end
    end

endmodule

//--- source/fetchPkg.sv
package fetchPkg;

    // R format: register operations
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat;

    // I format: immediates, loads, stores, branches
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormat;

    // J format: j and jal
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jFormat;

    typedef union packed {
        rFormat rType;
        iFormat iType;
        jFormat jType;
    } instrWord;

    localparam logic [5:0] OP_J   = 6'd2;  // Jump
    localparam logic [5:0] OP_JAL = 6'd3;  // Jump and link, link written later

    localparam logic [1:0] CFG_CTRL  = 2'd0;  // Bit 0 run, bit 1 restart
    localparam logic [1:0] CFG_BOOT  = 2'd1;  // Restart address
    localparam logic [1:0] CFG_COUNT = 2'd2;  // Delivered instructions, read only

endpackage

//--- verif/FetchStageTb.sv
`timescale 1ns/1ns

module FetchStageTb;

    import fetchPkg::*;

    localparam int MEM_WORDS      = 512;
    localparam int ADDR_BITS      = $clog2(MEM_WORDS);
    localparam int RESET_CYCLES   = 5;
    localparam int FILL_WORDS     = 64;             // All fetch paths stay in here
    localparam int TEST_BUDGET    = 80;             // Longest test in cycles
    localparam int TEST_CYCLES    = RESET_CYCLES + FILL_WORDS + 5 * TEST_BUDGET;
    localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

    logic                 clk;
    logic                 rstN;
    logic                 progWe;
    logic [ADDR_BITS-1:0] progAddr;
    logic [31:0]          progData;
    logic                 cfgWe;
    logic [1:0]           cfgAddr;
    logic [31:0]          cfgWdata;
    logic [31:0]          cfgRdata;
    logic                 stall;
    logic                 redirectValid;
    logic [31:0]          redirectPc;
    instrWord             idInstr;
    logic [31:0]          idPcPlus4;
    logic                 idValid;

    logic [31:0] shadow [0:MEM_WORDS-1];    // Copy of program memory
    logic        mRun;                      // Model state
    logic        mRestart;
    logic [31:0] mBoot;
    logic [31:0] mCount;
    logic [31:0] mPc;
    logic        mValid;
    logic [31:0] mInstr;
    logic [31:0] mPcPlus4;

    string testName;
    int    testsRun;
    int    testBase;
    int    cycleCount;
    int    compareChecks;
    int    compareErrors;
    int    readChecks;
    int    readErrors;
    int    i;
    int    target;

    FetchStage #(.MEM_WORDS(MEM_WORDS)) UUT (.*);

    always #4 clk = ~clk;

    // Next PC by restart, redirect, hold, jump, sequential
    function automatic logic [31:0] refNextPc(input logic [31:0] pc, input instrWord word,
        input logic run, input logic restart, input logic [31:0] boot,
        input logic stallIn, input logic redirV, input logic [31:0] redirPc);
        logic [31:0] pc4;
        pc4 = pc + 32'd4;
        if (restart) return boot;
        if (redirV) return redirPc;
        if (stallIn || !run) return pc;
        if (word.jType.opcode === OP_J || word.jType.opcode === OP_JAL) begin
            return {pc4[31:28], word.jType.target, 2'b00};
        end
        return pc4;
    endfunction

    // Expected IF/ID content as {valid, instr, pcPlus4}
    function automatic logic [64:0] refIfId(input logic [64:0] held, input logic [31:0] word,
        input logic [31:0] pc, input logic run, input logic restart,
        input logic stallIn, input logic redirV);
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc4;
        {valid, instr, pc4} = held;
        if (!stallIn) begin
            instr = word;
            pc4   = pc + 32'd4;
        end
        if (restart || redirV) valid = 1'b0;    // Bubble
        else if (!stallIn) valid = run;
        return {valid, instr, pc4};
    endfunction

    function automatic instrWord makeAdd(input int idx);
        instrWord w;
        w.rType.opcode = 6'h00;
        w.rType.rs     = idx[4:0];
        w.rType.rt     = {1'b0, idx[8:5]};
        w.rType.rd     = idx[4:0] ^ {1'b1, idx[8:5]};  // Whole index mixed in
        w.rType.shamt  = 5'd0;
        w.rType.funct  = 6'h20;
        return w;
    endfunction

    function automatic instrWord makeJump(input logic [5:0] op, input int targetWord);
        instrWord w;
        w.jType.opcode = op;
        w.jType.target = 26'(targetWord);
        return w;
    endfunction

    always @(posedge clk) begin : referenceModel
        instrWord    word;
        logic [31:0] nextPc;
        logic [64:0] nextId;
        if (!rstN) begin
            mRun     = 1'b0;
            mRestart = 1'b0;
            mBoot    = '0;
            mCount   = '0;
            mPc      = '0;
            mValid   = 1'b0;
        end else begin
            word   = shadow[mPc[ADDR_BITS+1:2]];        // Old contents, write lands after
            nextPc = refNextPc(mPc, word, mRun, mRestart, mBoot, stall, redirectValid,
                redirectPc);
            nextId = refIfId({mValid, mInstr, mPcPlus4}, word, mPc, mRun, mRestart, stall,
                redirectValid);
            if (mValid && !stall) mCount = mCount + 32'd1;
            mPc = nextPc;
            {mValid, mInstr, mPcPlus4} = nextId;
            mRestart = cfgWe && (cfgAddr == CFG_CTRL) && cfgWdata[1];
            if (cfgWe && (cfgAddr == CFG_CTRL)) mRun = cfgWdata[0];
            if (cfgWe && (cfgAddr == CFG_BOOT)) mBoot = cfgWdata;
        end
        if (progWe) shadow[progAddr] = progData;
    end

    // Compare mid cycle, outputs settled
    always @(negedge clk) begin
        if (rstN) begin
            compareChecks++;
            assert (idValid === mValid) else begin
                compareErrors++;
                $display("Mismatch in %s: idValid expected %b, actual %b",
                    testName, mValid, idValid);
            end
            if (mValid) begin
                assert (idInstr === mInstr) else begin
                    compareErrors++;
                    $display("Mismatch in %s: idInstr expected %h, actual %h",
                        testName, mInstr, idInstr);
                end
                assert (idPcPlus4 === mPcPlus4) else begin
                    compareErrors++;
                    $display("Mismatch in %s: idPcPlus4 expected %h, actual %h",
                        testName, mPcPlus4, idPcPlus4);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;                                 // Drive just after the edge
    endtask

    task automatic runCycles(input int n);
        repeat (n) nextCycle();
    endtask

    task automatic loadWord(input int idx, input logic [31:0] data);
        progWe   = 1'b1;
        progAddr = ADDR_BITS'(idx);
        progData = data;
        nextCycle();
        progWe   = 1'b0;
    endtask

    task automatic writeCfg(input logic [1:0] addr, input logic [31:0] data);
        cfgWe    = 1'b1;
        cfgAddr  = addr;
        cfgWdata = data;
        nextCycle();
        cfgWe    = 1'b0;
    endtask

    task automatic checkRead(input logic [1:0] addr, input logic [31:0] expected,
        input string what);
        cfgAddr = addr;
        #1;
        readChecks++;
        assert (cfgRdata === expected) else begin
            readErrors++;
            $display("Mismatch in %s: %s expected %h, actual %h",
                testName, what, expected, cfgRdata);
        end
        nextCycle();
    endtask

    task automatic startTest(input string name);
        testName = name;
        testBase = compareErrors + readErrors;
    endtask

    task automatic endTest();
        int failures;
        failures = compareErrors + readErrors - testBase;
        testsRun++;
        $display("Test %s %s with %0d errors", testName,
            (failures == 0) ? "passed" : "failed", failures);
    endtask

    initial begin
        void'($urandom(32'h8c18_ff64));
        clk           = 1'b0;
        rstN          = 1'b0;
        progWe        = 1'b0;
        progAddr      = '0;
        progData      = '0;
        cfgWe         = 1'b0;
        cfgAddr       = CFG_CTRL;
        cfgWdata      = '0;
        stall         = 1'b0;
        redirectValid = 1'b0;
        redirectPc    = '0;
        testName      = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstN = 1'b1;

        for (i = 0; i < FILL_WORDS; i++) loadWord(i, makeAdd(i));

        startTest("sequential");
        writeCfg(CFG_BOOT, 32'd0);
        writeCfg(CFG_CTRL, 32'd3);          // Run plus restart
        runCycles(20);
        endTest();

        startTest("jumps");
        writeCfg(CFG_CTRL, 32'd0);
        loadWord(30, makeJump(OP_J, 40));   // Skips words 31 to 39
        loadWord(42, makeJump(OP_JAL, 10)); // Loops back
        writeCfg(CFG_BOOT, 32'd112);
        writeCfg(CFG_CTRL, 32'd3);
        runCycles(40);
        endTest();

        startTest("stall");
        for (i = 0; i < 6; i++) begin
            runCycles($urandom_range(2, 5));
            stall = 1'b1;
            runCycles($urandom_range(1, 4));
            stall = 1'b0;
        end
        runCycles(3);
        endTest();

        startTest("redirect");
        for (i = 0; i < 6; i++) begin
            target = $urandom_range(0, 42);
            stall  = (i % 2 == 1);          // Every other redirect lands while stalled
            redirectValid = 1'b1;
            redirectPc    = 32'(target) << 2;
            nextCycle();
            redirectValid = 1'b0;
            runCycles(stall ? 1 : 0);
            stall = 1'b0;
            runCycles(4);
        end
        endTest();

        startTest("control");
        writeCfg(CFG_CTRL, 32'd0);          // Stop delivery
        runCycles(5);
        writeCfg(CFG_BOOT, 32'h14);
        checkRead(CFG_BOOT, 32'h14, "bootPc");
        writeCfg(CFG_CTRL, 32'd3);
        runCycles(10);
        checkRead(CFG_COUNT, mCount, "count");
        endTest();

        $display("Tests %0d, checks %0d, errors %0d", testsRun,
            compareChecks + readChecks, compareErrors + readErrors);
        if (compareErrors + readErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verif/FetchStage_checker.sv
`timescale 1ns/1ns

module FetchStage_checker (
    input logic               clk,
    input logic               rstN,
    input logic               stall,
    input logic               redirectValid,
    input logic               restart,        // Internal pulse from FetchControl
    input fetchPkg::instrWord idInstr,
    input logic [31:0]        idPcPlus4,
    input logic               idValid
);

    // Reset leaves IF/ID empty
    afterReset: assert property (@(posedge clk) !rstN |=> !idValid)
        else $error("idValid high in the cycle after reset");

    // A plain stalled edge must not disturb decode
    stallHold: assert property (@(posedge clk)
        (rstN && stall && !redirectValid && !restart)
        |=> ($stable(idValid) && $stable(idInstr) && $stable(idPcPlus4)))
        else $error("IF/ID outputs changed across a stalled edge");

    redirectBubble: assert property (@(posedge clk) (rstN && redirectValid) |=> !idValid)
        else $error("idValid high in the cycle after a redirect");

    pcAligned: assert property (@(posedge clk) rstN |-> (idPcPlus4[1:0] == 2'b00))
        else $error("idPcPlus4 is not word aligned");

endmodule

bind FetchStage FetchStage_checker fetchCheck (
    .clk          (clk),
    .rstN         (rstN),
    .stall        (stall),
    .redirectValid(redirectValid),
    .restart      (restart),
    .idInstr      (idInstr),
    .idPcPlus4    (idPcPlus4),
    .idValid      (idValid)
);

//--- verilog.f
source/fetchPkg.sv
source/InstructionMemory.sv
source/FetchControl.sv
source/ProgramCounter.sv
source/FetchDecodeReg.sv
source/FetchStage.sv
verif/FetchStage_checker.sv
verif/FetchStageTb.sv
